//--- verilog/backEnd_macros.svh
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

// Datapath and address width
`define DATA_W 32

// Register address width, 32 architectural registers
`define REG_AW 5

// Data memory depth in 32-bit words
`define DMEM_WORDS 64

// Forwarding selects into execute
`define FWD_NONE 2'd0
`define FWD_W    2'd1
`define FWD_M    2'd2

`endif

//--- verilog/backEndPkg.sv
`default_nettype none

`include "backEnd_macros.svh"

package backEndPkg;

  typedef enum logic [1:0] {
    kindAluReg,   // rd = rs1 op rs2
    kindAluImm,   // rd = rs1 op imm
    kindMem,      // Load or store, memWrite decides
    kindBranch
  } opKind_e;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra
  } aluFunc_e;

  typedef enum logic [1:0] {
    condBeq, condBne, condBlt, condBge
  } branchCond_e;

  typedef enum logic [1:0] {
    sizeByte, sizeHalf, sizeWord
  } memSize_e;

  // Decoded op as delivered by the front end
  typedef struct packed {
    opKind_e               kind;
    aluFunc_e              func;
    branchCond_e           cond;
    logic [`REG_AW-1:0]    rs1;
    logic [`REG_AW-1:0]    rs2;
    logic [`REG_AW-1:0]    rd;
    logic [`DATA_W-1:0]    imm;    // Already sign extended
    logic [`DATA_W-1:0]    pc;
    logic                  regWrite;
    logic                  memWrite;
    memSize_e              memSize;
    logic                  memSigned;
  } issueOp_t;

  typedef struct packed {
    logic                  valid;
    issueOp_t              op;
    logic [`DATA_W-1:0]    rs1Val;
    logic [`DATA_W-1:0]    rs2Val;
  } execIn_t;

  typedef struct packed {
    logic [`DATA_W-1:0]    aluResult;  // Also the memory address
    logic [`DATA_W-1:0]    storeData;
    logic [`REG_AW-1:0]    rd;
    logic                  regWrite;
    logic                  memWrite;
    logic                  memRead;
    memSize_e              memSize;
    logic                  memSigned;
  } memIn_t;

  typedef struct packed {
    logic                  valid;
    logic [`REG_AW-1:0]    rd;
    logic [`DATA_W-1:0]    value;
  } retire_t;

endpackage

`default_nettype wire

//--- verilog/regFile.sv
`default_nettype none

`include "backEnd_macros.svh"

module regFile (
  input  logic               clk,
  input  logic               reset,
  input  logic [`REG_AW-1:0] rs1,
  input  logic [`REG_AW-1:0] rs2,
  output logic [`DATA_W-1:0] rdData1,
  output logic [`DATA_W-1:0] rdData2,
  input  backEndPkg::retire_t wr
);

  logic [`DATA_W-1:0] regs [2**`REG_AW];
  logic               wrEn;

  assign wrEn = wr.valid && (wr.rd != '0);  // x0 is never written

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wrEn) begin
      regs[wr.rd] <= wr.value;
    end
  end

  // Same-cycle write shows up on the read ports
  assign rdData1 = (rs1 == '0) ? '0 :
                   (wrEn && wr.rd == rs1) ? wr.value : regs[rs1];
  assign rdData2 = (rs2 == '0) ? '0 :
                   (wrEn && wr.rd == rs2) ? wr.value : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/issueStage.sv
`default_nettype none

`include "backEnd_macros.svh"

module issueStage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 issueValid,
  input  backEndPkg::issueOp_t issueOp,
  output logic                 issueReady,
  input  logic                 stall,
  input  logic                 flushIssue,
  input  logic [`DATA_W-1:0]   rdData1,
  input  logic [`DATA_W-1:0]   rdData2,
  output logic [`REG_AW-1:0]   rs1,
  output logic [`REG_AW-1:0]   rs2,
  output backEndPkg::execIn_t  execOp
);

  import backEndPkg::*;

  issueOp_t op;
  logic     opValid;
  logic     started;   // Holds ready low for the first cycle out of reset
  logic     accept;
  logic     usesRs2;

  assign issueReady = started && !stall && !flushIssue;
  assign accept     = issueValid && issueReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
      opValid <= 1'b0;
      op      <= '0;
    end else begin
      started <= 1'b1;
      if (!stall) begin
        opValid <= accept;
        op      <= accept ? issueOp : '0;  // Empty or flushed slot is a bubble
      end
    end
  end

  // Only these kinds actually read rs2
  assign usesRs2 = (op.kind == kindAluReg) || (op.kind == kindBranch) ||
                   (op.kind == kindMem && op.memWrite);

  assign rs1 = op.rs1;
  assign rs2 = usesRs2 ? op.rs2 : '0;

  always_comb begin
    if (stall) begin
      execOp = '0;             // Bubble into execute while held
    end else begin
      execOp.valid  = opValid;
      execOp.op     = op;
      execOp.rs1Val = rdData1;
      execOp.rs2Val = rdData2;
    end
  end

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`default_nettype none

`include "backEnd_macros.svh"

module hazardUnit (
  input  logic [`REG_AW-1:0] issueRs1,
  input  logic [`REG_AW-1:0] issueRs2,
  input  logic [`REG_AW-1:0] execRs1,
  input  logic [`REG_AW-1:0] execRs2,
  input  logic [`REG_AW-1:0] execRd,
  input  logic [`REG_AW-1:0] memRd,
  input  logic [`REG_AW-1:0] wbRd,
  input  logic               execMemRead,
  input  logic               execValid,
  input  logic               memRegWrite,
  input  logic               wbRegWrite,
  input  logic               redirect,
  output logic [1:0]         forwardA,
  output logic [1:0]         forwardB,
  output logic               stall,
  output logic               flushIssue,
  output logic               flushExec
);

  // Youngest producer wins, so M is checked before W
  function automatic logic [1:0] fwdSel(input logic [`REG_AW-1:0] src);
    logic [1:0] sel;
    sel = `FWD_NONE;
    if (src != '0) begin
      if (memRegWrite && memRd == src) begin
        sel = `FWD_M;
      end else if (wbRegWrite && wbRd == src) begin
        sel = `FWD_W;
      end
    end
    return sel;
  endfunction

  assign forwardA = fwdSel(execRs1);
  assign forwardB = fwdSel(execRs2);

  // Load data only exists after M, one bubble lets W forwarding catch it
  assign stall = execValid && execMemRead && (execRd != '0) &&
                 ((execRd == issueRs1) || (execRd == issueRs2));

  assign flushIssue = redirect;
  assign flushExec  = redirect;

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none

`include "backEnd_macros.svh"

module alu (
  input  logic [`DATA_W-1:0]  a,
  input  logic [`DATA_W-1:0]  b,
  input  backEndPkg::aluFunc_e func,
  output logic [`DATA_W-1:0]  result,
  output logic                eq,
  output logic                lt
);

  import backEndPkg::*;

  localparam int ShW = $clog2(`DATA_W);

  logic [ShW-1:0] shamt;
  logic           ltSigned;
  logic           ltUnsigned;

  assign shamt      = b[ShW-1:0];       // Low five bits only
  assign ltSigned   = $signed(a) < $signed(b);
  assign ltUnsigned = a < b;

  always_comb begin
    case (func)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluXor:  result = a ^ b;
      aluSlt:  result = {{(`DATA_W-1){1'b0}}, ltSigned};
      aluSltu: result = {{(`DATA_W-1){1'b0}}, ltUnsigned};
      aluSll:  result = a << shamt;
      aluSrl:  result = a >> shamt;
      aluSra:  result = $signed(a) >>> shamt;  // Sign fills from the left
      default: result = '0;
    endcase
  end

  // Branch compares
  assign eq = (a == b);
  assign lt = ltSigned;

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`default_nettype none

`include "backEnd_macros.svh"

module executeStage (
  input  logic                clk,
  input  logic                reset,
  input  backEndPkg::execIn_t execIn,
  input  logic                flushExec,
  input  logic [1:0]          forwardA,
  input  logic [1:0]          forwardB,
  input  logic [`DATA_W-1:0]  memAluResult,
  input  logic [`DATA_W-1:0]  wbValue,
  output backEndPkg::memIn_t  execOut,
  output logic                redirectValid,
  output logic [`DATA_W-1:0]  redirectTarget,
  output logic [`REG_AW-1:0]  execRs1,
  output logic [`REG_AW-1:0]  execRs2,
  output logic [`REG_AW-1:0]  execRd,
  output logic                execMemRead,
  output logic                execValid
);

  import backEndPkg::*;

  execIn_t            e;
  logic [`DATA_W-1:0] srcA;
  logic [`DATA_W-1:0] srcB;
  logic [`DATA_W-1:0] opB;
  logic [`DATA_W-1:0] aluResult;
  aluFunc_e           func;
  logic               isMem;
  logic               eq;
  logic               lt;
  logic               taken;

  always_ff @(posedge clk) begin
    if (reset || flushExec) begin
      e <= '0;
    end else begin
      e <= execIn;
    end
  end

  always_comb begin
    case (forwardA)
      `FWD_M:  srcA = memAluResult;
      `FWD_W:  srcA = wbValue;
      default: srcA = e.rs1Val;
    endcase
    case (forwardB)
      `FWD_M:  srcB = memAluResult;
      `FWD_W:  srcB = wbValue;
      default: srcB = e.rs2Val;
    endcase
  end

  assign isMem = (e.op.kind == kindMem);
  assign opB   = (e.op.kind == kindAluReg || e.op.kind == kindBranch) ? srcB : e.op.imm;
  assign func  = isMem ? aluAdd : e.op.func;  // Address is always rs1 + imm

  alu aluInst (
    .a     (srcA),
    .b     (opB),
    .func  (func),
    .result(aluResult),
    .eq    (eq),
    .lt    (lt)
  );

  always_comb begin
    case (e.op.cond)
      condBeq: taken = eq;
      condBne: taken = !eq;
      condBlt: taken = lt;
      default: taken = !lt;  // bge
    endcase
  end

  assign redirectValid  = e.valid && (e.op.kind == kindBranch) && taken;
  assign redirectTarget = e.op.pc + e.op.imm;

  always_comb begin
    execOut.aluResult = aluResult;
    execOut.storeData = srcB;
    execOut.rd        = e.op.rd;
    execOut.regWrite  = e.valid && e.op.regWrite && (e.op.kind != kindBranch);
    execOut.memWrite  = e.valid && isMem && e.op.memWrite;
    execOut.memRead   = e.valid && isMem && !e.op.memWrite;
    execOut.memSize   = e.op.memSize;
    execOut.memSigned = e.op.memSigned;
  end

  // Hazard unit view of this stage, qualified there by execValid
  assign execRs1     = e.op.rs1;
  assign execRs2     = e.op.rs2;
  assign execRd      = e.op.rd;
  assign execMemRead = isMem && !e.op.memWrite;
  assign execValid   = e.valid;

endmodule

`default_nettype wire

//--- verilog/memStage.sv
`default_nettype none

`include "backEnd_macros.svh"

module memStage (
  input  logic               clk,
  input  logic               reset,
  input  backEndPkg::memIn_t memIn,
  output logic [`DATA_W-1:0] memAluResult,
  output logic [`REG_AW-1:0] memRd,
  output logic               memRegWrite,
  output backEndPkg::retire_t retire
);

  import backEndPkg::*;

  localparam int IdxW = $clog2(`DMEM_WORDS);

  memIn_t             m;
  logic [`DATA_W-1:0] dmem [`DMEM_WORDS];
  logic [IdxW-1:0]    wordIdx;
  logic [1:0]         byteOff;
  logic [3:0]         laneEn;
  logic [`DATA_W-1:0] laneData;
  logic [`DATA_W-1:0] shifted;
  logic [`DATA_W-1:0] loadValue;

  always_ff @(posedge clk) begin
    if (reset) begin
      m <= '0;
    end else begin
      m <= memIn;
    end
  end

  assign wordIdx = m.aluResult[IdxW+1:2];
  assign byteOff = m.aluResult[1:0];

  // Replicate the store data so each lane sees its own copy
  always_comb begin
    case (m.memSize)
      sizeByte: begin
        laneEn   = 4'b0001 << byteOff;
        laneData = {4{m.storeData[7:0]}};
      end
      sizeHalf: begin
        laneEn   = byteOff[1] ? 4'b1100 : 4'b0011;
        laneData = {2{m.storeData[15:0]}};
      end
      default: begin
        laneEn   = 4'b1111;
        laneData = m.storeData;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (m.memWrite) begin
      for (int i = 0; i < 4; i++) begin
        if (laneEn[i]) begin
          dmem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
        end
      end
    end
  end

  assign shifted = dmem[wordIdx] >> {byteOff, 3'b000};  // Addressed byte to bit 0

  always_comb begin
    case (m.memSize)
      sizeByte: loadValue = {{(`DATA_W-8){m.memSigned & shifted[7]}}, shifted[7:0]};
      sizeHalf: loadValue = {{(`DATA_W-16){m.memSigned & shifted[15]}}, shifted[15:0]};
      default:  loadValue = shifted;
    endcase
  end

  // W register
  always_ff @(posedge clk) begin
    if (reset) begin
      retire <= '0;
    end else begin
      retire.valid <= m.regWrite;
      retire.rd    <= m.rd;
      retire.value <= m.memRead ? loadValue : m.aluResult;
    end
  end

  assign memAluResult = m.aluResult;
  assign memRd        = m.rd;
  assign memRegWrite  = m.regWrite;

endmodule

`default_nettype wire

//--- verilog/backEnd.sv
`default_nettype none

`include "backEnd_macros.svh"

module backEnd (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 issueValid,
  input  backEndPkg::issueOp_t issueOp,
  output logic                 issueReady,
  output backEndPkg::retire_t  retire,
  output logic                 redirectValid,
  output logic [`DATA_W-1:0]   redirectTarget
);

  import backEndPkg::*;

  execIn_t            execIn;
  memIn_t             memIn;
  logic [`REG_AW-1:0] rs1;
  logic [`REG_AW-1:0] rs2;
  logic [`DATA_W-1:0] rdData1;
  logic [`DATA_W-1:0] rdData2;
  logic [1:0]         forwardA;
  logic [1:0]         forwardB;
  logic               stall;
  logic               flushIssue;
  logic               flushExec;
  logic [`REG_AW-1:0] execRs1;
  logic [`REG_AW-1:0] execRs2;
  logic [`REG_AW-1:0] execRd;
  logic               execMemRead;
  logic               execValid;
  logic [`DATA_W-1:0] memAluResult;
  logic [`REG_AW-1:0] memRd;
  logic               memRegWrite;

  regFile regFileInst (
    .clk(clk), .reset(reset),
    .rs1(rs1), .rs2(rs2),
    .rdData1(rdData1), .rdData2(rdData2),
    .wr(retire)                                // Writeback port
  );

  issueStage issueStageInst (
    .clk(clk), .reset(reset),
    .issueValid(issueValid), .issueOp(issueOp), .issueReady(issueReady),
    .stall(stall), .flushIssue(flushIssue),
    .rdData1(rdData1), .rdData2(rdData2),
    .rs1(rs1), .rs2(rs2),
    .execOp(execIn)
  );

  hazardUnit hazardUnitInst (
    .issueRs1(rs1), .issueRs2(rs2),
    .execRs1(execRs1), .execRs2(execRs2), .execRd(execRd),
    .memRd(memRd), .wbRd(retire.rd),
    .execMemRead(execMemRead), .execValid(execValid),
    .memRegWrite(memRegWrite), .wbRegWrite(retire.valid),
    .redirect(redirectValid),
    .forwardA(forwardA), .forwardB(forwardB),
    .stall(stall), .flushIssue(flushIssue), .flushExec(flushExec)
  );

  executeStage executeStageInst (
    .clk(clk), .reset(reset),
    .execIn(execIn), .flushExec(flushExec),
    .forwardA(forwardA), .forwardB(forwardB),
    .memAluResult(memAluResult), .wbValue(retire.value),
    .execOut(memIn),
    .redirectValid(redirectValid), .redirectTarget(redirectTarget),
    .execRs1(execRs1), .execRs2(execRs2), .execRd(execRd),
    .execMemRead(execMemRead), .execValid(execValid)
  );

  memStage memStageInst (
    .clk(clk), .reset(reset),
    .memIn(memIn),
    .memAluResult(memAluResult), .memRd(memRd), .memRegWrite(memRegWrite),
    .retire(retire)
  );

endmodule

`default_nettype wire

//--- bench/tb_backEnd.sv
`default_nettype none

`include "backEnd_macros.svh"

module tb_backEnd;

  import backEndPkg::*;

  logic               clk;
  logic               reset;
  logic               issueValid;
  issueOp_t           issueOp;
  logic               issueReady;
  retire_t            retire;
  logic               redirectValid;
  logic [`DATA_W-1:0] redirectTarget;

  logic [`DATA_W-1:0] modelRegs [32];
  logic [7:0]         modelMem [4*`DMEM_WORDS];  // Byte view of the data memory
  retire_t            expRetire [$];
  logic [`DATA_W-1:0] expRedirect [$];
  logic [31:0]        rngState;
  logic [`DATA_W-1:0] pcNext;
  string              curTest;
  int                 edgeCount = 0;
  int                 takenEdge;                 // Transfer edge of the last taken branch
  int                 lastWait;

  backEnd backEnd_inst (
    .clk(clk), .reset(reset),
    .issueValid(issueValid), .issueOp(issueOp), .issueReady(issueReady),
    .retire(retire),
    .redirectValid(redirectValid), .redirectTarget(redirectTarget)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    edgeCount <= edgeCount + 1;
  end

  task automatic stopWithFail();
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compareRetire(input retire_t expected, input retire_t actual);
    if (actual !== expected) begin
      $display("error %s: expected valid=%0b rd=%0d value=%h, actual valid=%0b rd=%0d value=%h",
               curTest, expected.valid, expected.rd, expected.value,
               actual.valid, actual.rd, actual.value);
      stopWithFail();
    end
  endtask

  task automatic compareRedirect(input logic [`DATA_W-1:0] expected,
                                 input logic [`DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("error %s: expected redirect target %h, actual %h", curTest, expected, actual);
      stopWithFail();
    end
  endtask

  task automatic compareCount(input int expected, input int actual);
    if (actual != expected) begin
      $display("error %s: expected %0d stall cycles, actual %0d", curTest, expected, actual);
      stopWithFail();
    end
  endtask

  // Retires must come out in issue order
  always @(negedge clk) begin : retireCheck
    retire_t expected;
    if (!reset && retire.valid === 1'b1) begin
      if (expRetire.size() == 0) begin
        $display("%s: x%0d retired but no retire was expected", curTest, retire.rd);
        stopWithFail();
      end else begin
        expected = expRetire.pop_front();
        compareRetire(expected, retire);
      end
    end
  end

  always @(negedge clk) begin : redirectCheck
    logic [`DATA_W-1:0] expected;
    if (!reset && redirectValid === 1'b1) begin
      if (expRedirect.size() == 0) begin
        $display("%s: redirect seen for a branch that should fall through", curTest);
        stopWithFail();
      end else begin
        expected = expRedirect.pop_front();
        compareRedirect(expected, redirectTarget);
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic logic [31:0] aluResultOf(input aluFunc_e func, input logic [31:0] a,
                                              input logic [31:0] b);
    case (func)
      aluAdd:  return a + b;
      aluSub:  return a - b;
      aluAnd:  return a & b;
      aluOr:   return a | b;
      aluXor:  return a ^ b;
      aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      aluSltu: return (a < b) ? 32'd1 : 32'd0;
      aluSll:  return a << b[4:0];
      aluSrl:  return a >> b[4:0];
      default: return $signed(a) >>> b[4:0];
    endcase
  endfunction

  function automatic logic branchTakenOf(input branchCond_e cond, input logic [31:0] a,
                                         input logic [31:0] b);
    case (cond)
      condBeq: return a == b;
      condBne: return a != b;
      condBlt: return $signed(a) < $signed(b);
      default: return $signed(a) >= $signed(b);
    endcase
  endfunction

  // Little endian, bytes beyond the access size are ignored
  function automatic logic [31:0] loadValueOf(input memSize_e size, input logic sgn,
                                              input logic [31:0] addr);
    logic [31:0] raw;
    for (int k = 0; k < 4; k++) begin
      raw[8*k +: 8] = modelMem[8'(addr + k)];
    end
    case (size)
      sizeByte: return {{24{sgn & raw[7]}}, raw[7:0]};
      sizeHalf: return {{16{sgn & raw[15]}}, raw[15:0]};
      default:  return raw;
    endcase
  endfunction

  task automatic storeToModel(input memSize_e size, input logic [31:0] addr,
                              input logic [31:0] data);
    int nBytes;
    nBytes = (size == sizeByte) ? 1 : (size == sizeHalf) ? 2 : 4;
    for (int k = 0; k < nBytes; k++) begin
      modelMem[8'(addr + k)] = data[8*k +: 8];
    end
  endtask

  task automatic updateModel(input issueOp_t op);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    retire_t     r;
    a   = modelRegs[op.rs1];
    b   = modelRegs[op.rs2];
    res = '0;
    case (op.kind)
      kindAluReg: res = aluResultOf(op.func, a, b);
      kindAluImm: res = aluResultOf(op.func, a, op.imm);
      kindMem: begin
        if (op.memWrite) begin
          storeToModel(op.memSize, a + op.imm, b);
        end else begin
          res = loadValueOf(op.memSize, op.memSigned, a + op.imm);
        end
      end
      default: begin
        if (branchTakenOf(op.cond, a, b)) begin
          expRedirect.push_back(op.pc + op.imm);
          takenEdge = edgeCount;
        end
      end
    endcase
    if (op.regWrite && op.kind != kindBranch && !(op.kind == kindMem && op.memWrite)) begin
      r.valid = 1'b1;
      r.rd    = op.rd;
      r.value = res;
      expRetire.push_back(r);
      if (op.rd != '0) begin
        modelRegs[op.rd] = res;           // x0 keeps zero
      end
    end
  endtask

  function automatic issueOp_t makeAlu(input opKind_e kind, input aluFunc_e func,
                                       input int rd, input int rs1, input int rs2,
                                       input logic [31:0] imm);
    issueOp_t op;
    op          = '0;
    op.kind     = kind;
    op.func     = func;
    op.rd       = 5'(rd);
    op.rs1      = 5'(rs1);
    op.rs2      = 5'(rs2);
    op.imm      = imm;
    op.regWrite = 1'b1;
    return op;
  endfunction

  function automatic issueOp_t makeMem(input logic write, input memSize_e size, input logic sgn,
                                       input int rd, input int rs1, input int rs2,
                                       input logic [31:0] imm);
    issueOp_t op;
    op           = makeAlu(kindMem, aluAdd, rd, rs1, rs2, imm);
    op.regWrite  = !write;
    op.memWrite  = write;
    op.memSize   = size;
    op.memSigned = sgn;
    return op;
  endfunction

  function automatic issueOp_t makeBranch(input branchCond_e cond, input int rs1, input int rs2,
                                          input logic [31:0] imm);
    issueOp_t op;
    op          = makeAlu(kindBranch, aluSub, 0, rs1, rs2, imm);
    op.cond     = cond;
    op.regWrite = 1'b0;
    return op;
  endfunction

  // Hold the op on the port until the DUT takes it
  task automatic sendOp(input issueOp_t op);
    int   waits;
    logic ready;
    logic done;
    op.pc      = pcNext;
    pcNext     = pcNext + 4;
    issueValid = 1'b1;
    issueOp    = op;
    waits      = 0;
    done       = 1'b0;
    while (!done && waits < 20) begin
      @(negedge clk);
      ready = issueReady;
      @(posedge clk);
      #1;
      if (ready) begin
        done = 1'b1;
      end else begin
        waits++;
      end
    end
    issueValid = 1'b0;
    lastWait   = waits;
    if (!done) begin
      $display("%s: issue port stayed not ready for 20 cycles", curTest);
      stopWithFail();
    end else if (takenEdge != edgeCount - 1) begin
      updateModel(op);                    // Op right behind a taken branch is squashed
    end
  endtask

  task automatic offerDuringRedirect(input issueOp_t op);
    issueValid = 1'b1;
    issueOp    = op;
    @(negedge clk);
    if (issueReady !== 1'b0 || redirectValid !== 1'b1) begin
      $display("%s: issue port was open while a taken branch was in execute", curTest);
      stopWithFail();
    end
    @(posedge clk);
    #1;
    issueValid = 1'b0;                    // Front end drops it after the redirect
  endtask

  task automatic drain();
    int waits;
    waits = 0;
    while ((expRetire.size() != 0 || expRedirect.size() != 0) && waits < 20) begin
      @(posedge clk);
      #1;
      waits++;
    end
    if (expRetire.size() != 0 || expRedirect.size() != 0) begin
      $display("%s: %0d retires and %0d redirects still missing after 20 cycles",
               curTest, expRetire.size(), expRedirect.size());
      stopWithFail();
    end
  endtask

  task automatic checkResetState();
    @(negedge clk);
    if (issueReady !== 1'b0 || retire.valid !== 1'b0 || redirectValid !== 1'b0) begin
      $display("issue ready, retire or redirect was high in the first cycle after reset");
      stopWithFail();
    end
    @(posedge clk);
    #1;
  endtask

  task automatic testAluChain();
    curTest = "testAluChain";
    sendOp(makeAlu(kindAluImm, aluAdd, 1, 0, 0, nextRand()));
    sendOp(makeAlu(kindAluImm, aluAdd, 2, 0, 0, nextRand()));
    for (int i = 0; i < 10; i++) begin
      sendOp(makeAlu(kindAluReg, aluFunc_e'(4'(i)), 3 + i, 2 + i, 1 + i, '0));  // M and W fwd
    end
    for (int i = 0; i < 10; i++) begin
      sendOp(makeAlu(kindAluImm, aluFunc_e'(4'(i)), 13 + i, 12 + i, 0, nextRand()));
    end
    drain();
  endtask

  task automatic testLoadStore();
    curTest = "testLoadStore";
    sendOp(makeAlu(kindAluImm, aluAdd, 5, 0, 0, 32'd64));              // Base address
    sendOp(makeAlu(kindAluImm, aluAdd, 6, 0, 0, nextRand() | 32'h8080_8080));
    sendOp(makeAlu(kindAluImm, aluAdd, 7, 0, 0, nextRand() & 32'h7f7f_7f7f));
    sendOp(makeMem(1'b1, sizeWord, 1'b0, 0, 5, 6, 0));
    sendOp(makeMem(1'b1, sizeWord, 1'b0, 0, 5, 7, 4));
    sendOp(makeMem(1'b1, sizeWord, 1'b0, 0, 5, 6, 8));
    sendOp(makeMem(1'b1, sizeByte, 1'b0, 0, 5, 7, 1));
    sendOp(makeMem(1'b1, sizeByte, 1'b0, 0, 5, 7, 3));
    sendOp(makeMem(1'b1, sizeByte, 1'b0, 0, 5, 6, 6));
    sendOp(makeMem(1'b1, sizeHalf, 1'b0, 0, 5, 6, 4));
    sendOp(makeMem(1'b1, sizeHalf, 1'b0, 0, 5, 7, 10));
    for (int k = 0; k < 12; k++) begin
      sendOp(makeMem(1'b0, sizeByte, 1'b1, 8, 5, 0, k));
      sendOp(makeMem(1'b0, sizeByte, 1'b0, 9, 5, 0, k));
    end
    for (int k = 0; k < 12; k += 2) begin
      sendOp(makeMem(1'b0, sizeHalf, 1'b1, 8, 5, 0, k));
      sendOp(makeMem(1'b0, sizeHalf, 1'b0, 9, 5, 0, k));
    end
    for (int k = 0; k < 12; k += 4) begin
      sendOp(makeMem(1'b0, sizeWord, 1'b0, 8, 5, 0, k));
    end
    drain();
  endtask

  task automatic testLoadUse();
    curTest = "testLoadUse";
    sendOp(makeMem(1'b0, sizeWord, 1'b0, 10, 5, 0, 0));
    sendOp(makeAlu(kindAluReg, aluAdd, 11, 10, 6, '0));      // Needs the load on rs1
    sendOp(makeAlu(kindAluImm, aluAdd, 12, 0, 0, 32'd1));
    compareCount(1, lastWait);
    sendOp(makeMem(1'b0, sizeByte, 1'b1, 13, 5, 0, 1));
    sendOp(makeAlu(kindAluReg, aluSub, 14, 6, 13, '0));      // Needs it on rs2
    sendOp(makeAlu(kindAluImm, aluAdd, 15, 0, 0, 32'd2));
    compareCount(1, lastWait);
    drain();
  endtask

  task automatic runBranch(input branchCond_e cond, input int rs1, input int rs2);
    logic [31:0] v;
    logic        taken;
    v = nextRand();
    sendOp(makeBranch(cond, rs1, rs2, {{22{v[9]}}, v[9:2], 2'b00}));
    taken = (takenEdge == edgeCount);
    sendOp(makeAlu(kindAluImm, aluAdd, 24, 0, 0, 32'h5a5a_0001));
    if (taken) begin
      offerDuringRedirect(makeAlu(kindAluImm, aluAdd, 25, 0, 0, 32'h5a5a_0002));
    end else begin
      sendOp(makeAlu(kindAluImm, aluAdd, 25, 0, 0, 32'h5a5a_0002));
    end
  endtask

  task automatic testBranch();
    curTest = "testBranch";
    sendOp(makeAlu(kindAluImm, aluAdd, 20, 0, 0, -7));
    sendOp(makeAlu(kindAluImm, aluAdd, 21, 0, 0, 32'd3));
    sendOp(makeAlu(kindAluImm, aluAdd, 22, 0, 0, 32'd3));
    runBranch(condBeq, 21, 22);
    runBranch(condBeq, 20, 21);
    runBranch(condBne, 20, 21);
    runBranch(condBne, 21, 22);
    runBranch(condBlt, 20, 21);           // Signed, so -7 is below 3
    runBranch(condBlt, 21, 20);
    runBranch(condBge, 21, 20);
    runBranch(condBge, 20, 21);
    runBranch(condBge, 21, 22);
    drain();
  endtask

  task automatic testRandom();
    logic [31:0] r;
    logic [31:0] v;
    int          rd;
    aluFunc_e    func;
    opKind_e     kind;
    curTest = "testRandom";
    for (int i = 1; i < 32; i++) begin
      sendOp(makeAlu(kindAluImm, aluAdd, i, 0, 0, nextRand()));
    end
    for (int n = 0; n < 200; n++) begin
      r    = nextRand();
      v    = nextRand();
      rd   = (r[26:24] == 3'b000) ? 0 : int'(r[4:0]);  // About one in eight writes x0
      kind = r[15] ? kindAluReg : kindAluImm;
      func = aluFunc_e'(4'(r[23:16] % 8'd10));
      sendOp(makeAlu(kind, func, rd, int'(r[9:5]), int'(r[14:10]), {{20{v[11]}}, v[11:0]}));
    end
    sendOp(makeAlu(kindAluImm, aluAdd, 0, 0, 0, 32'd123));
    sendOp(makeAlu(kindAluReg, aluOr, 3, 0, 0, '0));         // x0 must not forward
    sendOp(makeAlu(kindAluImm, aluAdd, 4, 0, 0, '0));
    drain();
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    issueValid = 1'b0;
    issueOp    = '0;
    rngState   = 32'h9828_a300;
    pcNext     = 32'h0000_1000;
    curTest    = "reset";
    takenEdge  = -10;
    lastWait   = 0;
    for (int i = 0; i < 32; i++) begin
      modelRegs[i] = '0;
    end
    for (int i = 0; i < 4*`DMEM_WORDS; i++) begin
      modelMem[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    checkResetState();
    testAluChain();
    testLoadStore();
    testLoadUse();
    testBranch();
    testRandom();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+verilog
verilog/backEndPkg.sv
verilog/regFile.sv
verilog/issueStage.sv
verilog/hazardUnit.sv
verilog/alu.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/backEnd.sv
bench/tb_backEnd.sv

//--- run.sh
#!/usr/bin/env bash
# Build the backEnd testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module tb_backEnd -f build.f -o simBackEnd || exit 1
simOut="$(./obj_dir/simBackEnd 2>&1)"
echo "$simOut"
echo "$simOut" | grep -qx "Verification passed" && exit 0 || exit 1
